//--- i2c_ctrl_pkg.sv
`default_nettype none

package i2c_ctrl_pkg;

    //////////////////////////////////////////////////
    // Bus data
    //////////////////////////////////////////////////

    // One byte as it goes out on SDA, MSB first
    typedef logic [7:0] byte_t;

    // Power-up command list for the mezzanine board
    localparam int NUM_CMD_BYTES = 5;

    typedef logic [$clog2(NUM_CMD_BYTES)-1:0] cmd_idx_t;

    // Transaction 0 selects channel 7 on the bus switch at 7'h71
    // Transaction 1 writes the CPLD control register at 7'h3E, LED on
    localparam byte_t CMD_BYTES [NUM_CMD_BYTES] = '{
        8'hE2,
        8'h80,
        8'h7C,
        8'h02,
        8'h01
    };

    // Bit n set when byte n closes its transaction
    localparam logic [NUM_CMD_BYTES-1:0] CMD_LAST = 5'b10010;

    //////////////////////////////////////////////////
    // State and op encodings
    //////////////////////////////////////////////////

    // Ops handed from the sequencer to the bit engine
    typedef enum logic [1:0] {OP_START, OP_WRITE, OP_STOP} bus_op_e;

    // Command level, one state per outstanding op plus the end states
    typedef enum logic [2:0] {S_IDLE, S_START, S_WRITE, S_STOP, S_DONE, S_FAIL} seq_state_e;

    // Bus phase level, each phase lasts half an SCL period
    typedef enum logic [3:0] {
        P_IDLE, P_START_HI, P_START_LO, P_BIT_LOW, P_BIT_HIGH,
        P_ACK_LOW, P_ACK_HIGH, P_STOP_LOW, P_STOP_HIGH
    } phy_state_e;

endpackage

`default_nettype wire

//--- i2c_line_filter.sv
`default_nettype none

module i2c_line_filter #(
    parameter int FILTER_STAGES = 2
) (
    input  logic CLK,
    input  logic reset,
    input  logic scl_i,
    input  logic sda_i,
    output logic scl_f_o,
    output logic sda_f_o
);

    // Both lines travel side by side, bit 1 is SCL and bit 0 is SDA
    logic [1:0] pad;
    logic [1:0] sync_q [FILTER_STAGES];
    logic [1:0] agree;

    assign pad = {scl_i, sda_i};

    // Last two synchronizer taps must match before the output may move
    // A one clock glitch never sits in both taps at once
    assign agree = ~(sync_q[FILTER_STAGES-1] ^ sync_q[FILTER_STAGES-2]);

    always_ff @(posedge CLK) begin
        if (reset) begin
            // Lines read as released until the chain has filled
            for (int i = 0; i < FILTER_STAGES; i++) begin
                sync_q[i] <= 2'b11;
            end
            scl_f_o <= 1'b1;
            sda_f_o <= 1'b1;
        end else begin
            sync_q[0] <= pad;
            for (int i = 1; i < FILTER_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            // Hold the old level unless the taps agree
            if (agree[1]) begin
                scl_f_o <= sync_q[FILTER_STAGES-1][1];
            end
            if (agree[0]) begin
                sda_f_o <= sync_q[FILTER_STAGES-1][0];
            end
        end
    end

endmodule

`default_nettype wire

//--- i2c_cmd_sequencer.sv
`default_nettype none

module i2c_cmd_sequencer #(
    parameter int CLK_DIV     = 4,
    parameter int MAX_RETRIES = 2
) (
    input  logic                  CLK,
    input  logic                  reset,
    input  logic                  scl_f_i,
    input  logic                  sda_f_i,
    input  logic                  op_done_i,
    input  logic                  ack_ok_i,
    output logic                  op_go_o,
    output i2c_ctrl_pkg::bus_op_e op_o,
    output i2c_ctrl_pkg::byte_t   op_byte_o,
    output logic                  done_o,
    output logic                  fail_o,
    output logic                  busy_o
);

    import i2c_ctrl_pkg::*;

    // Bus must read free for a full SCL period before the first start
    localparam int IDLE_CYCLES = 4 * CLK_DIV;
    localparam int IW          = $clog2(IDLE_CYCLES + 1);
    // Room for one count past the limit
    localparam int RW          = $clog2(MAX_RETRIES + 2);

    seq_state_e    state_q;
    cmd_idx_t      idx_q;
    cmd_idx_t      first_idx_q;
    logic [IW-1:0] idle_cnt_q;
    logic [RW-1:0] retry_cnt_q;
    logic          nack_q;
    logic          bus_free;

    assign bus_free = scl_f_i && sda_f_i;

    //////////////////////////////////////////////////
    // Op and status outputs
    //////////////////////////////////////////////////

    // State already names the op in the op_go cycle
    always_comb begin
        case (state_q)
            S_START: op_o = OP_START;
            S_WRITE: op_o = OP_WRITE;
            default: op_o = OP_STOP;
        endcase
    end

    assign op_byte_o = CMD_BYTES[idx_q];

    assign done_o = (state_q == S_DONE);
    assign fail_o = (state_q == S_FAIL);
    assign busy_o = (state_q != S_IDLE) && !done_o && !fail_o;

    //////////////////////////////////////////////////
    // Command walk
    //////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (reset) begin
            state_q     <= S_IDLE;
            idx_q       <= '0;
            first_idx_q <= '0;
            idle_cnt_q  <= '0;
            retry_cnt_q <= '0;
            nack_q      <= 1'b0;
            op_go_o     <= 1'b0;
        end else begin
            op_go_o <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    // Any low level restarts the free-bus count
                    if (!bus_free) begin
                        idle_cnt_q <= '0;
                    end else if (idle_cnt_q == IW'(IDLE_CYCLES - 1)) begin
                        op_go_o <= 1'b1;
                        state_q <= S_START;
                    end else begin
                        idle_cnt_q <= idle_cnt_q + 1'b1;
                    end
                end
                S_START: begin
                    if (op_done_i) begin
                        op_go_o <= 1'b1;
                        state_q <= S_WRITE;
                    end
                end
                S_WRITE: begin
                    if (op_done_i) begin
                        // Stop unless an acked byte has more behind it
                        op_go_o <= 1'b1;
                        state_q <= S_STOP;
                        if (!ack_ok_i) begin
                            nack_q      <= 1'b1;
                            retry_cnt_q <= retry_cnt_q + 1'b1;
                        end else if (!CMD_LAST[idx_q]) begin
                            idx_q   <= idx_q + 1'b1;
                            state_q <= S_WRITE;
                        end else begin
                            nack_q <= 1'b0;
                        end
                    end
                end
                S_STOP: begin
                    if (op_done_i) begin
                        if (nack_q) begin
                            // Failed attempt, go again from the address byte
                            if (retry_cnt_q > RW'(MAX_RETRIES)) begin
                                state_q <= S_FAIL;
                            end else begin
                                idx_q   <= first_idx_q;
                                op_go_o <= 1'b1;
                                state_q <= S_START;
                            end
                        end else if (idx_q == cmd_idx_t'(NUM_CMD_BYTES - 1)) begin
                            state_q <= S_DONE;
                        end else begin
                            // Next transaction gets a fresh retry budget
                            idx_q       <= idx_q + 1'b1;
                            first_idx_q <= idx_q + 1'b1;
                            retry_cnt_q <= '0;
                            op_go_o     <= 1'b1;
                            state_q     <= S_START;
                        end
                    end
                end
                default: begin
                    // S_DONE and S_FAIL hold until reset
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- i2c_bit_engine.sv
`default_nettype none

module i2c_bit_engine #(
    parameter int CLK_DIV      = 4,
    parameter int SETUP_CYCLES = 1
) (
    input  logic                  CLK,
    input  logic                  reset,
    input  logic                  op_go_i,
    input  i2c_ctrl_pkg::bus_op_e op_i,
    input  i2c_ctrl_pkg::byte_t   op_byte_i,
    input  logic                  sda_f_i,
    output logic                  op_done_o,
    output logic                  ack_ok_o,
    output logic                  scl_oe_o,
    output logic                  sda_oe_o
);

    import i2c_ctrl_pkg::*;

    // Wide enough for CLK_DIV-1 and for SETUP_CYCLES
    localparam int QW = $clog2(CLK_DIV + 1);

    phy_state_e    state_q;
    logic [QW-1:0] q_cnt_q;
    logic          q_sub_q;
    logic [QW-1:0] setup_cnt_q;
    logic [2:0]    bit_cnt_q;
    byte_t         sh_q;
    logic          quarter_end;
    logic          phase_end;
    logic          setup_hit;

    //////////////////////////////////////////////////
    // SCL timing generator
    //////////////////////////////////////////////////

    // Two quarters make one phase, SCL moves only on phase boundaries
    assign quarter_end = (q_cnt_q == QW'(CLK_DIV - 1));
    assign phase_end   = quarter_end && q_sub_q;

    always_ff @(posedge CLK) begin
        if (reset) begin
            q_cnt_q <= '0;
            q_sub_q <= 1'b0;
        end else if (state_q == P_IDLE || phase_end) begin
            // Restarts with every op so op timing is exact
            q_cnt_q <= '0;
            q_sub_q <= 1'b0;
        end else if (quarter_end) begin
            q_cnt_q <= '0;
            q_sub_q <= 1'b1;
        end else begin
            q_cnt_q <= q_cnt_q + 1'b1;
        end
    end

    // Data setup delay after SCL falls, SETUP_CYCLES is at least 1
    assign setup_hit = (setup_cnt_q == QW'(1));

    //////////////////////////////////////////////////
    // Byte shifter
    //////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (state_q == P_IDLE && op_go_i) begin
            sh_q <= op_byte_i;
        end else if (state_q == P_BIT_HIGH && phase_end) begin
            sh_q <= {sh_q[6:0], 1'b0};
        end
    end

    //////////////////////////////////////////////////
    // Bus phase FSM
    //////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (reset) begin
            state_q     <= P_IDLE;
            scl_oe_o    <= 1'b0;
            sda_oe_o    <= 1'b0;
            op_done_o   <= 1'b0;
            ack_ok_o    <= 1'b0;
            setup_cnt_q <= '0;
            bit_cnt_q   <= '0;
        end else begin
            op_done_o <= 1'b0;
            if (setup_cnt_q != '0) begin
                setup_cnt_q <= setup_cnt_q - 1'b1;
            end
            case (state_q)
                // Lines keep whatever the last op left on them
                P_IDLE: begin
                    if (op_go_i) begin
                        case (op_i)
                            OP_START: state_q <= P_START_HI;
                            OP_WRITE: begin
                                state_q     <= P_BIT_LOW;
                                bit_cnt_q   <= 3'd7;
                                setup_cnt_q <= QW'(SETUP_CYCLES);
                            end
                            default: begin
                                state_q     <= P_STOP_LOW;
                                setup_cnt_q <= QW'(SETUP_CYCLES);
                            end
                        endcase
                    end
                end
                // Start is SDA falling while SCL is high
                P_START_HI: begin
                    if (phase_end) begin
                        sda_oe_o <= 1'b1;
                        state_q  <= P_START_LO;
                    end
                end
                P_START_LO: begin
                    if (phase_end) begin
                        scl_oe_o  <= 1'b1;
                        op_done_o <= 1'b1;
                        state_q   <= P_IDLE;
                    end
                end
                P_BIT_LOW: begin
                    // Open drain, a 1 bit releases the line
                    if (setup_hit) begin
                        sda_oe_o <= ~sh_q[7];
                    end
                    if (phase_end) begin
                        scl_oe_o <= 1'b0;
                        state_q  <= P_BIT_HIGH;
                    end
                end
                P_BIT_HIGH: begin
                    if (phase_end) begin
                        scl_oe_o    <= 1'b1;
                        setup_cnt_q <= QW'(SETUP_CYCLES);
                        if (bit_cnt_q == 3'd0) begin
                            state_q <= P_ACK_LOW;
                        end else begin
                            bit_cnt_q <= bit_cnt_q - 1'b1;
                            state_q   <= P_BIT_LOW;
                        end
                    end
                end
                // Hand SDA to the slave for the ninth bit
                P_ACK_LOW: begin
                    if (setup_hit) begin
                        sda_oe_o <= 1'b0;
                    end
                    if (phase_end) begin
                        scl_oe_o <= 1'b0;
                        state_q  <= P_ACK_HIGH;
                    end
                end
                P_ACK_HIGH: begin
                    // Sample at the very end of SCL high, slave pulls low for ack
                    if (phase_end) begin
                        scl_oe_o  <= 1'b1;
                        ack_ok_o  <= ~sda_f_i;
                        op_done_o <= 1'b1;
                        state_q   <= P_IDLE;
                    end
                end
                // Stop is SDA rising while SCL is high, so pull SDA low first
                P_STOP_LOW: begin
                    if (setup_hit) begin
                        sda_oe_o <= 1'b1;
                    end
                    if (phase_end) begin
                        scl_oe_o <= 1'b0;
                        state_q  <= P_STOP_HIGH;
                    end
                end
                P_STOP_HIGH: begin
                    if (phase_end) begin
                        sda_oe_o  <= 1'b0;
                        op_done_o <= 1'b1;
                        state_q   <= P_IDLE;
                    end
                end
                default: state_q <= P_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- i2c_ctrl_top.sv
`default_nettype none

module i2c_ctrl_top #(
    parameter int CLK_DIV       = 4,
    parameter int SETUP_CYCLES  = 1,
    parameter int FILTER_STAGES = 2,
    parameter int MAX_RETRIES   = 2
) (
    input  logic CLK,
    input  logic reset,
    input  logic scl_i,
    input  logic sda_i,
    output logic scl_oe_o,
    output logic sda_oe_o,
    output logic done_o,
    output logic fail_o,
    output logic busy_o
);

    import i2c_ctrl_pkg::*;

    // Filtered pad levels
    logic    scl_f;
    logic    sda_f;

    // Op channel, one op in flight at a time
    logic    op_go;
    bus_op_e op;
    byte_t   op_byte;
    logic    op_done;
    logic    ack_ok;

    //////////////////////////////////////////////////
    // Front end, decode and execute
    //////////////////////////////////////////////////

    i2c_line_filter #(
        .FILTER_STAGES (FILTER_STAGES)
    ) u_filter (
        .CLK     (CLK),
        .reset   (reset),
        .scl_i   (scl_i),
        .sda_i   (sda_i),
        .scl_f_o (scl_f),
        .sda_f_o (sda_f)
    );

    i2c_cmd_sequencer #(
        .CLK_DIV     (CLK_DIV),
        .MAX_RETRIES (MAX_RETRIES)
    ) u_seq (
        .CLK       (CLK),
        .reset     (reset),
        .scl_f_i   (scl_f),
        .sda_f_i   (sda_f),
        .op_done_i (op_done),
        .ack_ok_i  (ack_ok),
        .op_go_o   (op_go),
        .op_o      (op),
        .op_byte_o (op_byte),
        .done_o    (done_o),
        .fail_o    (fail_o),
        .busy_o    (busy_o)
    );

    // SCL is driven only, no clock stretching
    i2c_bit_engine #(
        .CLK_DIV      (CLK_DIV),
        .SETUP_CYCLES (SETUP_CYCLES)
    ) u_engine (
        .CLK       (CLK),
        .reset     (reset),
        .op_go_i   (op_go),
        .op_i      (op),
        .op_byte_i (op_byte),
        .sda_f_i   (sda_f),
        .op_done_o (op_done),
        .ack_ok_o  (ack_ok),
        .scl_oe_o  (scl_oe_o),
        .sda_oe_o  (sda_oe_o)
    );

endmodule

`default_nettype wire

//--- i2c_ctrl_chk.sv
`default_nettype none

module i2c_ctrl_chk #(
    parameter int CLK_DIV = 4
) (
    input  logic                     CLK,
    input  logic                     reset,
    input  logic                     scl_oe_i,
    input  logic                     sda_oe_i,
    input  logic                     done_i,
    input  logic                     fail_i,
    input  logic                     op_go_i,
    input  logic                     op_done_i,
    input  i2c_ctrl_pkg::seq_state_e seq_state_i
);

    timeunit 1ns;
    timeprecision 100ps;

    import i2c_ctrl_pkg::*;

    // Longest op is a byte write of 9 bits at 4T each
    localparam int OP_LIMIT = 36 * CLK_DIV;

    logic op_open;
    int   op_age;
    // Read by the testbench watchdog
    int   assert_fails = 0;

    //////////////////////////////////////////////////
    // Age of the op in flight
    //////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (reset) begin
            op_open <= 1'b0;
            op_age  <= 0;
        end else if (op_go_i) begin
            op_open <= 1'b1;
            op_age  <= 0;
        end else if (op_done_i) begin
            op_open <= 1'b0;
        end else if (op_open) begin
            op_age <= op_age + 1;
        end
    end

    // SDA may only move under a released SCL for start or stop
    sda_edge_ok: assert property (@(posedge CLK) disable iff (reset)
        ($changed(sda_oe_i) && !scl_oe_i && !$past(scl_oe_i))
            |-> (seq_state_i == S_START || seq_state_i == S_STOP))
    else begin
        $error("SDA moved while SCL high outside start or stop");
        assert_fails++;
    end

    // A final status holds until reset and never turns into the other one
    status_held: assert property (@(posedge CLK) disable iff (reset)
        (done_i || fail_i) |=> ((done_i != fail_i) && $stable({done_i, fail_i})))
    else begin
        $error("done and fail not a single steady status before reset");
        assert_fails++;
    end

    op_time_ok: assert property (@(posedge CLK) disable iff (reset)
        op_open |-> (op_age <= OP_LIMIT))
    else begin
        $error("bus op outstanding for more than 36T");
        assert_fails++;
    end

endmodule

bind i2c_ctrl_top i2c_ctrl_chk #(
    .CLK_DIV (CLK_DIV)
) u_chk (
    .CLK         (CLK),
    .reset       (reset),
    .scl_oe_i    (scl_oe_o),
    .sda_oe_i    (sda_oe_o),
    .done_i      (done_o),
    .fail_i      (fail_o),
    .op_go_i     (op_go),
    .op_done_i   (op_done),
    .seq_state_i (u_seq.state_q)
);

`default_nettype wire

//--- i2c_ctrl_tb.sv
`default_nettype none

module i2c_ctrl_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import i2c_ctrl_pkg::*;

    // DUT parameters
    localparam int CLK_DIV       = 4;
    localparam int SETUP_CYCLES  = 1;
    localparam int FILTER_STAGES = 2;
    localparam int MAX_RETRIES   = 2;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_ROWS     = 5;
    // Every attempt of every byte at 40T plus reset and idle time per row
    localparam int TIMEOUT_CYCLES =
        NUM_ROWS * (MAX_RETRIES + 1) * NUM_CMD_BYTES * 40 * CLK_DIV
        + NUM_ROWS * (RESET_CYCLES + 8 * CLK_DIV + 50);

    // Log markers sit above the byte range 0 to 255
    localparam int MARK_START = 256;
    localparam int MARK_STOP  = 257;

    //////////////////////////////////////////////////
    // Scenario table
    //////////////////////////////////////////////////

    // Byte index to refuse or -1 for none
    int   row_refuse [NUM_ROWS] = '{-1, 2, 1, 4, 4};
    // How many times the slave refuses it
    int   row_times  [NUM_ROWS] = '{0, 1, 99, 2, 3};
    logic row_done   [NUM_ROWS] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0};
    logic row_fail   [NUM_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1};

    logic CLK   = 1'b0;
    logic reset = 1'b1;
    logic scl_i = 1'b1;
    logic sda_i = 1'b1;
    logic scl_oe;
    logic sda_oe;
    logic done;
    logic fail;
    logic busy;

    // Slave configuration for the current row
    int refuse_idx   = -1;
    int refuse_times = 0;

    // Slave state owned by the bus model
    logic  slave_on   = 1'b0;
    logic  slave_pull = 1'b0;
    logic  ack_this   = 1'b1;
    logic  in_frame   = 1'b0;
    logic  scl_prev   = 1'b1;
    logic  sda_prev   = 1'b1;
    int    bit_cnt    = 0;
    int    refused    = 0;
    byte_t shift_q    = '0;
    int    log_q [$];
    int    exp_q [$];

    i2c_ctrl_top #(
        .CLK_DIV       (CLK_DIV),
        .SETUP_CYCLES  (SETUP_CYCLES),
        .FILTER_STAGES (FILTER_STAGES),
        .MAX_RETRIES   (MAX_RETRIES)
    ) u_i2c_ctrl_top (
        .CLK      (CLK),
        .reset    (reset),
        .scl_i    (scl_i),
        .sda_i    (sda_i),
        .scl_oe_o (scl_oe),
        .sda_oe_o (sda_oe),
        .done_o   (done),
        .fail_o   (fail),
        .busy_o   (busy)
    );

    initial begin
        forever #4 CLK = ~CLK;
    end

    task automatic check_val(input string name, input int got, input int want);
        if (got !== want) begin
            $display("FAIL t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, want);
            $display("test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Inputs move 1 ns after the rising edge where outputs are stable
    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    //////////////////////////////////////////////////
    // Open-drain bus and slave model
    //////////////////////////////////////////////////

    always @(posedge CLK) begin : bus_model
        logic in_reset;
        logic scl_now;
        logic sda_now;
        // Reset is sampled at the edge since it only moves 1 ns later
        in_reset = reset;
        #1;
        if (in_reset) begin
            slave_on   = 1'b0;
            slave_pull = 1'b0;
            in_frame   = 1'b0;
            bit_cnt    = 0;
            refused    = 0;
            log_q.delete();
        end
        scl_now = !scl_oe;
        sda_now = !(sda_oe || slave_pull);
        if (scl_now && scl_prev && sda_prev && !sda_now) begin
            // Start is SDA falling under high SCL
            log_q.push_back(MARK_START);
            slave_on = 1'b1;
            in_frame = 1'b1;
            bit_cnt  = 0;
            check_val("busy_o at start", int'(busy), 1);
        end else if (scl_now && scl_prev && !sda_prev && sda_now) begin
            // Stop is SDA rising under high SCL
            log_q.push_back(MARK_STOP);
            slave_on   = 1'b0;
            slave_pull = 1'b0;
            bit_cnt    = 0;
            check_val("busy_o at stop", int'(busy), 1);
        end else if (slave_on && scl_now && !scl_prev) begin
            if (bit_cnt < 8) begin
                shift_q = {shift_q[6:0], sda_now};
                bit_cnt++;
                if (bit_cnt == 8) begin
                    log_q.push_back(int'(shift_q));
                    ack_this = 1'b1;
                    if (refuse_idx >= 0 && refused < refuse_times &&
                        shift_q == CMD_BYTES[cmd_idx_t'(refuse_idx)]) begin
                        ack_this = 1'b0;
                        refused++;
                    end
                end
            end else begin
                // Ninth clock is the acknowledge
                bit_cnt = 9;
            end
        end else if (slave_on && !scl_now && scl_prev) begin
            if (bit_cnt == 8) begin
                slave_pull = ack_this;
            end else if (bit_cnt == 9) begin
                slave_pull = 1'b0;
                bit_cnt    = 0;
            end
        end
        scl_prev = scl_now;
        sda_prev = !(sda_oe || slave_pull);
        scl_i    = scl_now;
        sda_i    = sda_prev;
        if (done || fail) begin
            check_val("busy_o after end", int'(busy), 0);
        end else if (in_frame) begin
            check_val("busy_o in frame", int'(busy), 1);
        end
    end

    //////////////////////////////////////////////////
    // Expected bus log
    //////////////////////////////////////////////////

    // Each transaction runs from its first byte to the CMD_LAST byte
    // A refused byte ends the attempt with a stop and a fresh start
    task automatic build_expected(input int r);
        int   first;
        int   idx;
        int   attempts;
        logic nacked;
        logic tr_last;
        logic tr_done;
        logic failed;
        int   n_refused;
        exp_q.delete();
        first     = 0;
        failed    = 1'b0;
        n_refused = 0;
        while (first < NUM_CMD_BYTES && !failed) begin
            attempts = 0;
            tr_done  = 1'b0;
            while (!tr_done) begin
                exp_q.push_back(MARK_START);
                idx     = first;
                nacked  = 1'b0;
                tr_last = 1'b0;
                while (!nacked && !tr_last) begin
                    exp_q.push_back(int'(CMD_BYTES[cmd_idx_t'(idx)]));
                    if (idx == row_refuse[r] && n_refused < row_times[r]) begin
                        n_refused++;
                        nacked = 1'b1;
                    end else if (CMD_LAST[cmd_idx_t'(idx)]) begin
                        tr_last = 1'b1;
                    end else begin
                        idx++;
                    end
                end
                exp_q.push_back(MARK_STOP);
                if (nacked) begin
                    attempts++;
                    if (attempts > MAX_RETRIES) begin
                        failed  = 1'b1;
                        tr_done = 1'b1;
                    end
                end else begin
                    tr_done = 1'b1;
                    first   = idx + 1;
                end
            end
        end
    endtask

    task automatic run_row(input int r);
        next_cycle();
        reset        = 1'b1;
        refuse_idx   = row_refuse[r];
        refuse_times = row_times[r];
        repeat (RESET_CYCLES) next_cycle();
        reset = 1'b0;
        next_cycle();
        // Quiet bus right after reset
        check_val("scl_oe_o", int'(scl_oe), 0);
        check_val("sda_oe_o", int'(sda_oe), 0);
        check_val("done_o", int'(done), 0);
        check_val("fail_o", int'(fail), 0);
        check_val("busy_o", int'(busy), 0);
        while (!(done || fail)) begin
            next_cycle();
        end
        check_val("done_o", int'(done), int'(row_done[r]));
        check_val("fail_o", int'(fail), int'(row_fail[r]));
        build_expected(r);
        check_val("log length", log_q.size(), exp_q.size());
        for (int i = 0; i < exp_q.size(); i++) begin
            check_val($sformatf("log[%0d]", i), log_q[i], exp_q[i]);
        end
    endtask

    initial begin : main_seq
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        if (u_i2c_ctrl_top.u_chk.assert_fails == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("bus checker flagged %0d assertion failures",
                     u_i2c_ctrl_top.u_chk.assert_fails);
            $display("test failed");
            $fatal(1, "assertion failures");
        end
    end

    // Ends a hung run or a run the checker has flagged
    initial begin : watchdog
        int cycle_cnt;
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES && u_i2c_ctrl_top.u_chk.assert_fails == 0) begin
            @(posedge CLK);
            cycle_cnt++;
        end
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout, no done or fail within %0d cycles", TIMEOUT_CYCLES);
        end else begin
            $display("bus checker flagged an assertion failure");
        end
        $display("test failed");
        $fatal(1, "run aborted");
    end

endmodule

`default_nettype wire

//--- files.f
i2c_ctrl_pkg.sv
i2c_line_filter.sv
i2c_cmd_sequencer.sv
i2c_bit_engine.sv
i2c_ctrl_top.sv
i2c_ctrl_chk.sv
i2c_ctrl_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= i2c_ctrl_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
